/* tb.f */
+incdir+source
source/l15_bridge_pkg.sv
source/req_slot_if.sv
source/req_capture.sv
source/req_issue.sv
source/resp_decoder.sv
source/l15_bridge_top.sv
dv/l15_bridge_chk.sv
dv/l15_bridge_tb.sv

/* dv/l15_bridge_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_bridge_params.svh"

module l15_bridge_tb;

    typedef struct packed {
        logic [4:0]             rqtype;
        logic [2:0]             size;
        logic [`BR_PADDR_W-1:0] addr;
        logic [`BR_WORD_W-1:0]  data;
    } req_t;

    logic                          clk;
    logic                          rst_n;
    logic                          ic_req_val_i;
    logic [`BR_IC_BLK_W-1:0]       ic_req_addr_i;
    logic                          dc_ld_val_i;
    logic [`BR_DC_BLK_W-1:0]       dc_ld_addr_i;
    logic                          dc_st_val_i;
    logic [`BR_PADDR_W-1:0]        dc_st_addr_i;
    logic [`BR_WORD_W-1:0]         dc_st_data_i;
    logic [2:0]                    dc_st_size_i;
    logic                          l15_val_o;
    l15_bridge_pkg::rqtype_e       l15_rqtype_o;
    l15_bridge_pkg::size_e         l15_size_o;
    logic [`BR_PADDR_W-1:0]        l15_addr_o;
    logic [`BR_WORD_W-1:0]         l15_data_o;
    logic                          l15_nc_o;
    logic                          l15_ack_i;
    logic                          l15_ret_val_i;
    l15_bridge_pkg::rettype_e      l15_ret_type_i;
    logic [`BR_PADDR_W-1:0]        l15_ret_addr_i;
    logic [`BR_WORD_W-1:0]         l15_ret_data0_i;
    logic [`BR_WORD_W-1:0]         l15_ret_data1_i;
    logic [`BR_WORD_W-1:0]         l15_ret_data2_i;
    logic [`BR_WORD_W-1:0]         l15_ret_data3_i;
    logic                          l15_ret_ack_o;
    logic                          mem_ic_fill_val_o;
    logic [`BR_TAG_W-1:0]          mem_ic_tag_o;
    logic [`BR_IC_IDX_W-1:0]       mem_ic_idx_o;
    logic [`BR_IC_LINE_W-1:0]      mem_ic_line_o;
    logic                          mem_dc_ld_val_o;
    logic [`BR_TAG_W-1:0]          mem_dc_tag_o;
    logic [`BR_DC_IDX_W-1:0]       mem_dc_idx_o;
    logic [`BR_DC_LINE_W-1:0]      mem_dc_line_o;
    logic                          mem_dc_st_done_o;
    logic                          int_o;

    // model of requests, in the order they should issue
    req_t        exp_q[$];
    logic [31:0] rng_state;
    int          err_cnt;
    int          err_base;
    int          tests_ok;
    int          tests_bad;

    l15_bridge_top i_l15_bridge_top (.*);

    always #2 clk = ~clk;

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // byte 0 of the word becomes byte 7
    function automatic logic [63:0] rev_word(input logic [63:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24], w[39:32], w[47:40], w[55:48], w[63:56]};
    endfunction

    task automatic report_mismatch(input string name, input logic [255:0] got,
                                   input logic [255:0] exp);
        err_cnt++;
        $display("mismatch %s: got %0h, expected %0h", name, got, exp);
    endtask

    task automatic report_error(input string msg);
        err_cnt++;
        $display("error: %s", msg);
    endtask

    task automatic abort_run(input string why);
        $display("error: %s", why);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_base) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    task automatic check_req(input req_t e);
        if (l15_rqtype_o !== e.rqtype)
            report_mismatch("l15_rqtype_o", l15_rqtype_o, e.rqtype);
        if (l15_size_o !== e.size)
            report_mismatch("l15_size_o", l15_size_o, e.size);
        if (l15_addr_o !== e.addr)
            report_mismatch("l15_addr_o", l15_addr_o, e.addr);
        if (l15_data_o !== e.data)
            report_mismatch("l15_data_o", l15_data_o, e.data);
        if (l15_nc_o !== e.addr[`BR_PADDR_W-1])
            report_mismatch("l15_nc_o", l15_nc_o, e.addr[`BR_PADDR_W-1]);
    endtask

    // one cycle of core requests, pushed to the model by priority
    task automatic drive_reqs(input bit do_i, input bit do_l, input bit do_s);
        logic [63:0] r_i;
        logic [63:0] r_l;
        logic [63:0] r_a;
        logic [63:0] r_d;
        logic [2:0]  sz;
        req_t        e;
        r_i = {next_rand(), next_rand()};
        r_l = {next_rand(), next_rand()};
        r_a = {next_rand(), next_rand()};
        r_d = {next_rand(), next_rand()};
        sz  = 3'(next_rand());
        @(posedge clk);
        ic_req_val_i  <= do_i;
        ic_req_addr_i <= r_i[`BR_IC_BLK_W-1:0];
        dc_ld_val_i   <= do_l;
        dc_ld_addr_i  <= r_l[`BR_DC_BLK_W-1:0];
        dc_st_val_i   <= do_s;
        dc_st_addr_i  <= r_a[`BR_PADDR_W-1:0];
        dc_st_data_i  <= r_d;
        dc_st_size_i  <= sz;
        if (do_i) begin
            e.rqtype = l15_bridge_pkg::IMISS_RQ;
            e.size   = l15_bridge_pkg::SZ_4B;
            e.addr   = {r_i[`BR_IC_BLK_W-1:0], 5'b0};
            e.data   = '0;
            exp_q.push_back(e);
        end
        if (do_l) begin
            e.rqtype = l15_bridge_pkg::LOAD_RQ;
            e.size   = l15_bridge_pkg::SZ_16B;
            e.addr   = {r_l[`BR_DC_BLK_W-1:0], 4'b0};
            e.data   = '0;
            exp_q.push_back(e);
        end
        if (do_s) begin
            e.rqtype = l15_bridge_pkg::STORE_RQ;
            e.size   = sz;
            e.addr   = r_a[`BR_PADDR_W-1:0];
            e.data   = rev_word(r_d);
            exp_q.push_back(e);
        end
        @(posedge clk);
        ic_req_val_i <= 1'b0;
        dc_ld_val_i  <= 1'b0;
        dc_st_val_i  <= 1'b0;
    endtask

    // edges counted from the one that sampled the core valid
    task automatic serve_req(input int max_delay, output int edges);
        req_t e;
        int   hold;
        edges = 0;
        while (l15_val_o !== 1'b1) begin
            @(negedge clk);
            edges++;
            if (edges > 50)
                abort_run("timeout waiting for l15_val_o");
        end
        if (exp_q.size() == 0)
            abort_run("request issued with nothing pending in the model");
        e = exp_q.pop_front();
        hold = next_rand() % (max_delay + 1);
        check_req(e);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            if (l15_val_o !== 1'b1)
                report_error("l15_val_o dropped before ack");
            check_req(e);
        end
        @(posedge clk);
        l15_ack_i <= 1'b1;
        @(posedge clk);
        l15_ack_i <= 1'b0;
        @(negedge clk);
        if (l15_val_o !== 1'b0)
            report_mismatch("l15_val_o after ack", l15_val_o, 1'b0);
    endtask

    task automatic expect_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (l15_val_o !== 1'b0)
                abort_run("extra request issued that the model does not expect");
        end
        if (exp_q.size() != 0)
            report_error($sformatf("%0d requests were never issued", exp_q.size()));
        exp_q.delete();
    endtask

    task automatic send_return();
        logic [31:0]              sel;
        logic [63:0]              ra;
        logic [63:0]              w0;
        logic [63:0]              w1;
        logic [63:0]              w2;
        logic [63:0]              w3;
        l15_bridge_pkg::rettype_e t;
        sel = next_rand() % 5;
        ra  = {next_rand(), next_rand()};
        w0  = {next_rand(), next_rand()};
        w1  = {next_rand(), next_rand()};
        w2  = {next_rand(), next_rand()};
        w3  = {next_rand(), next_rand()};
        case (sel)
            0:       t = l15_bridge_pkg::LOAD_RET;
            1:       t = l15_bridge_pkg::IFILL_RET;
            2:       t = l15_bridge_pkg::ST_ACK;
            3:       t = l15_bridge_pkg::INT_RET;
            default: t = l15_bridge_pkg::rettype_e'(4'b1010);
        endcase
        @(posedge clk);
        l15_ret_val_i   <= 1'b1;
        l15_ret_type_i  <= t;
        l15_ret_addr_i  <= ra[`BR_PADDR_W-1:0];
        l15_ret_data0_i <= w0;
        l15_ret_data1_i <= w1;
        l15_ret_data2_i <= w2;
        l15_ret_data3_i <= w3;
        @(negedge clk);
        if (l15_ret_ack_o !== 1'b1)
            report_mismatch("l15_ret_ack_o", l15_ret_ack_o, 1'b1);
        if (mem_ic_fill_val_o !== (t == l15_bridge_pkg::IFILL_RET))
            report_mismatch("mem_ic_fill_val_o", mem_ic_fill_val_o, sel == 1);
        if (mem_dc_ld_val_o !== (t == l15_bridge_pkg::LOAD_RET))
            report_mismatch("mem_dc_ld_val_o", mem_dc_ld_val_o, sel == 0);
        if (mem_dc_st_done_o !== (t == l15_bridge_pkg::ST_ACK))
            report_mismatch("mem_dc_st_done_o", mem_dc_st_done_o, sel == 2);
        if (int_o !== 1'b0)
            report_mismatch("int_o", int_o, 1'b0);
        // tag on top, index right below it
        if (mem_ic_tag_o !== ra[39:11])
            report_mismatch("mem_ic_tag_o", mem_ic_tag_o, ra[39:11]);
        if (mem_dc_tag_o !== ra[39:11])
            report_mismatch("mem_dc_tag_o", mem_dc_tag_o, ra[39:11]);
        if (mem_ic_idx_o !== ra[10:5])
            report_mismatch("mem_ic_idx_o", mem_ic_idx_o, ra[10:5]);
        if (mem_dc_idx_o !== ra[10:4])
            report_mismatch("mem_dc_idx_o", mem_dc_idx_o, ra[10:4]);
        if (mem_ic_line_o !== {rev_word(w3), rev_word(w2), rev_word(w1), rev_word(w0)})
            report_mismatch("mem_ic_line_o", mem_ic_line_o,
                            {rev_word(w3), rev_word(w2), rev_word(w1), rev_word(w0)});
        if (mem_dc_line_o !== {rev_word(w1), rev_word(w0)})
            report_mismatch("mem_dc_line_o", mem_dc_line_o, {rev_word(w1), rev_word(w0)});
        @(posedge clk);
        l15_ret_val_i <= 1'b0;
        @(negedge clk);
        if (int_o !== (t == l15_bridge_pkg::INT_RET))
            report_mismatch("int_o pulse", int_o, sel == 3);
        if (l15_ret_ack_o !== 1'b0)
            report_mismatch("l15_ret_ack_o", l15_ret_ack_o, 1'b0);
        @(negedge clk);
        if (int_o !== 1'b0)
            report_mismatch("int_o after pulse", int_o, 1'b0);
    endtask

    initial begin
        int edges;
        clk             = 1'b0;
        rst_n           = 1'b0;
        ic_req_val_i    = 1'b0;
        ic_req_addr_i   = '0;
        dc_ld_val_i     = 1'b0;
        dc_ld_addr_i    = '0;
        dc_st_val_i     = 1'b0;
        dc_st_addr_i    = '0;
        dc_st_data_i    = '0;
        dc_st_size_i    = '0;
        l15_ack_i       = 1'b0;
        l15_ret_val_i   = 1'b0;
        l15_ret_type_i  = l15_bridge_pkg::LOAD_RET;
        l15_ret_addr_i  = '0;
        l15_ret_data0_i = '0;
        l15_ret_data1_i = '0;
        l15_ret_data2_i = '0;
        l15_ret_data3_i = '0;
        rng_state       = 32'hb1e9;
        err_cnt         = 0;
        err_base        = 0;
        tests_ok        = 0;
        tests_bad       = 0;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (l15_val_o !== 1'b0)
            report_mismatch("l15_val_o after reset", l15_val_o, 1'b0);
        if (int_o !== 1'b0)
            report_mismatch("int_o after reset", int_o, 1'b0);
        end_test("reset");

        drive_reqs(1'b1, 1'b0, 1'b0);
        serve_req(0, edges);
        if (edges != 2)
            report_mismatch("l15_val_o rise edge", edges, 2);
        expect_idle(4);
        end_test("single_imiss");

        repeat (10) begin
            drive_reqs(1'b0, 1'b0, 1'b1);
            serve_req(3, edges);
        end
        expect_idle(4);
        end_test("store_format");

        repeat (6) begin
            drive_reqs(1'b1, 1'b1, 1'b1);
            repeat (3) serve_req(7, edges);
        end
        expect_idle(4);
        end_test("priority");

        // imiss and load arrive while the store is held
        repeat (6) begin
            drive_reqs(1'b0, 1'b0, 1'b1);
            drive_reqs(1'b1, 1'b1, 1'b0);
            repeat (3) serve_req(15, edges);
        end
        expect_idle(6);
        end_test("back_pressure");

        repeat (24) send_return();
        end_test("returns");

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/l15_bridge_chk.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_bridge_params.svh"

module l15_bridge_chk (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   l15_val_o,
    input logic                   l15_ack_i,
    input logic [4:0]             l15_rqtype_o,
    input logic [2:0]             l15_size_o,
    input logic [`BR_PADDR_W-1:0] l15_addr_o,
    input logic [`BR_WORD_W-1:0]  l15_data_o,
    input logic                   mem_ic_fill_val_o,
    input logic                   mem_dc_ld_val_o,
    input logic                   mem_dc_st_done_o,
    input logic                   int_o
);

    logic [5+3+`BR_PADDR_W+`BR_WORD_W-1:0] req_bits;

    assign req_bits = {l15_rqtype_o, l15_size_o, l15_addr_o, l15_data_o};

    // request frozen until the L1.5 takes it
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (l15_val_o && !l15_ack_i) |=> (l15_val_o && $stable(req_bits)))
        else $error("l15 request changed or dropped while waiting for ack");

    resp_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({mem_ic_fill_val_o, mem_dc_ld_val_o, mem_dc_st_done_o}))
        else $error("more than one response strobe high");

    // wake-up is a single cycle pulse
    int_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        int_o |=> !int_o)
        else $error("int_o high two cycles running");

    val_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (l15_val_o && l15_ack_i) |=> !l15_val_o)
        else $error("l15_val_o did not fall after ack");

endmodule

bind l15_bridge_top l15_bridge_chk i_l15_bridge_chk (
    .clk               (clk),
    .rst_n             (rst_n),
    .l15_val_o         (l15_val_o),
    .l15_ack_i         (l15_ack_i),
    .l15_rqtype_o      (l15_rqtype_o),
    .l15_size_o        (l15_size_o),
    .l15_addr_o        (l15_addr_o),
    .l15_data_o        (l15_data_o),
    .mem_ic_fill_val_o (mem_ic_fill_val_o),
    .mem_dc_ld_val_o   (mem_dc_ld_val_o),
    .mem_dc_st_done_o  (mem_dc_st_done_o),
    .int_o             (int_o)
);

`default_nettype wire

/* source/l15_bridge_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_bridge_params.svh"

module l15_bridge_top (
    input  logic                          clk,
    input  logic                          rst_n,

    // core icache miss
    input  logic                          ic_req_val_i,
    input  logic [`BR_IC_BLK_W-1:0]       ic_req_addr_i,

    // core dcache load miss and store
    input  logic                          dc_ld_val_i,
    input  logic [`BR_DC_BLK_W-1:0]       dc_ld_addr_i,
    input  logic                          dc_st_val_i,
    input  logic [`BR_PADDR_W-1:0]        dc_st_addr_i,
    input  logic [`BR_WORD_W-1:0]         dc_st_data_i,
    input  logic [2:0]                    dc_st_size_i,

    // request to the L1.5
    output logic                          l15_val_o,
    output l15_bridge_pkg::rqtype_e       l15_rqtype_o,
    output l15_bridge_pkg::size_e         l15_size_o,
    output logic [`BR_PADDR_W-1:0]        l15_addr_o,
    output logic [`BR_WORD_W-1:0]         l15_data_o,
    output logic                          l15_nc_o,
    input  logic                          l15_ack_i,

    // return from the L1.5
    input  logic                          l15_ret_val_i,
    input  l15_bridge_pkg::rettype_e      l15_ret_type_i,
    input  logic [`BR_PADDR_W-1:0]        l15_ret_addr_i,
    input  logic [`BR_WORD_W-1:0]         l15_ret_data0_i,
    input  logic [`BR_WORD_W-1:0]         l15_ret_data1_i,
    input  logic [`BR_WORD_W-1:0]         l15_ret_data2_i,
    input  logic [`BR_WORD_W-1:0]         l15_ret_data3_i,
    output logic                          l15_ret_ack_o,

    // responses to the core caches
    output logic                          mem_ic_fill_val_o,
    output logic [`BR_TAG_W-1:0]          mem_ic_tag_o,
    output logic [`BR_IC_IDX_W-1:0]       mem_ic_idx_o,
    output logic [`BR_IC_LINE_W-1:0]      mem_ic_line_o,
    output logic                          mem_dc_ld_val_o,
    output logic [`BR_TAG_W-1:0]          mem_dc_tag_o,
    output logic [`BR_DC_IDX_W-1:0]       mem_dc_idx_o,
    output logic [`BR_DC_LINE_W-1:0]      mem_dc_line_o,
    output logic                          mem_dc_st_done_o,
    output logic                          int_o
);

    // pending slots between capture and issue
    req_slot_if slot_if ();

    req_capture i_req_capture (
        .clk           (clk),
        .rst_n         (rst_n),
        .ic_req_val_i  (ic_req_val_i),
        .ic_req_addr_i (ic_req_addr_i),
        .dc_ld_val_i   (dc_ld_val_i),
        .dc_ld_addr_i  (dc_ld_addr_i),
        .dc_st_val_i   (dc_st_val_i),
        .dc_st_addr_i  (dc_st_addr_i),
        .dc_st_data_i  (dc_st_data_i),
        .dc_st_size_i  (dc_st_size_i),
        .slot          (slot_if.capture)
    );

    req_issue i_req_issue (
        .clk           (clk),
        .rst_n         (rst_n),
        .l15_ack_i     (l15_ack_i),
        .slot          (slot_if.issue),
        .l15_val_o     (l15_val_o),
        .l15_rqtype_o  (l15_rqtype_o),
        .l15_size_o    (l15_size_o),
        .l15_addr_o    (l15_addr_o),
        .l15_data_o    (l15_data_o),
        .l15_nc_o      (l15_nc_o)
    );

    resp_decoder i_resp_decoder (
        .clk               (clk),
        .rst_n             (rst_n),
        .l15_ret_val_i     (l15_ret_val_i),
        .l15_ret_type_i    (l15_ret_type_i),
        .l15_ret_addr_i    (l15_ret_addr_i),
        .l15_ret_data0_i   (l15_ret_data0_i),
        .l15_ret_data1_i   (l15_ret_data1_i),
        .l15_ret_data2_i   (l15_ret_data2_i),
        .l15_ret_data3_i   (l15_ret_data3_i),
        .l15_ret_ack_o     (l15_ret_ack_o),
        .mem_ic_fill_val_o (mem_ic_fill_val_o),
        .mem_ic_tag_o      (mem_ic_tag_o),
        .mem_ic_idx_o      (mem_ic_idx_o),
        .mem_ic_line_o     (mem_ic_line_o),
        .mem_dc_ld_val_o   (mem_dc_ld_val_o),
        .mem_dc_tag_o      (mem_dc_tag_o),
        .mem_dc_idx_o      (mem_dc_idx_o),
        .mem_dc_line_o     (mem_dc_line_o),
        .mem_dc_st_done_o  (mem_dc_st_done_o),
        .int_o             (int_o)
    );

endmodule

`default_nettype wire

/* source/resp_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_bridge_params.svh"

module resp_decoder (
    input  logic                          clk,
    input  logic                          rst_n,

    // return from the L1.5
    input  logic                          l15_ret_val_i,
    input  l15_bridge_pkg::rettype_e      l15_ret_type_i,
    input  logic [`BR_PADDR_W-1:0]        l15_ret_addr_i,
    input  logic [`BR_WORD_W-1:0]         l15_ret_data0_i,
    input  logic [`BR_WORD_W-1:0]         l15_ret_data1_i,
    input  logic [`BR_WORD_W-1:0]         l15_ret_data2_i,
    input  logic [`BR_WORD_W-1:0]         l15_ret_data3_i,
    output logic                          l15_ret_ack_o,

    // icache fill
    output logic                          mem_ic_fill_val_o,
    output logic [`BR_TAG_W-1:0]          mem_ic_tag_o,
    output logic [`BR_IC_IDX_W-1:0]       mem_ic_idx_o,
    output logic [`BR_IC_LINE_W-1:0]      mem_ic_line_o,

    // dcache load fill
    output logic                          mem_dc_ld_val_o,
    output logic [`BR_TAG_W-1:0]          mem_dc_tag_o,
    output logic [`BR_DC_IDX_W-1:0]       mem_dc_idx_o,
    output logic [`BR_DC_LINE_W-1:0]      mem_dc_line_o,

    output logic                          mem_dc_st_done_o,
    output logic                          int_o
);

    l15_bridge_pkg::fill_addr_u ret_addr;
    logic                       int_hit;

    // every return is taken at once
    assign l15_ret_ack_o = l15_ret_val_i;

    // one strobe per known type, unknown types are ignored
    always_comb begin
        mem_ic_fill_val_o = 1'b0;
        mem_dc_ld_val_o   = 1'b0;
        mem_dc_st_done_o  = 1'b0;
        int_hit           = 1'b0;
        if (l15_ret_val_i) begin
            case (l15_ret_type_i)
                l15_bridge_pkg::IFILL_RET: mem_ic_fill_val_o = 1'b1;
                l15_bridge_pkg::LOAD_RET:  mem_dc_ld_val_o   = 1'b1;
                l15_bridge_pkg::ST_ACK:    mem_dc_st_done_o  = 1'b1;
                l15_bridge_pkg::INT_RET:   int_hit           = 1'b1;
                default:                   int_hit           = 1'b0;
            endcase
        end
    end

    // tag and index differ per cache
    assign ret_addr     = l15_ret_addr_i;
    assign mem_ic_tag_o = ret_addr.ic.tag;
    assign mem_ic_idx_o = ret_addr.ic.idx;
    assign mem_dc_tag_o = ret_addr.dc.tag;
    assign mem_dc_idx_o = ret_addr.dc.idx;

    // icache gets all four words, dcache the low two
    assign mem_ic_line_o = l15_bridge_pkg::swap_line(
        {l15_ret_data3_i, l15_ret_data2_i, l15_ret_data1_i, l15_ret_data0_i});
    assign mem_dc_line_o = {l15_bridge_pkg::swap_bytes64(l15_ret_data1_i),
                            l15_bridge_pkg::swap_bytes64(l15_ret_data0_i)};

    // wake-up pulse, the cycle after the return
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_o <= 1'b0;
        end else begin
            int_o <= int_hit;
        end
    end

endmodule

`default_nettype wire

/* source/req_issue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_bridge_params.svh"

module req_issue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          l15_ack_i,

    req_slot_if.issue                     slot,

    // request to the L1.5
    output logic                          l15_val_o,
    output l15_bridge_pkg::rqtype_e       l15_rqtype_o,
    output l15_bridge_pkg::size_e         l15_size_o,
    output logic [`BR_PADDR_W-1:0]        l15_addr_o,
    output logic [`BR_WORD_W-1:0]         l15_data_o,
    output logic                          l15_nc_o
);

    logic                          outstanding;
    logic                          ack_hit;

    // winner among the pending slots
    logic                          pick_val;
    l15_bridge_pkg::rqtype_e       pick_type;
    l15_bridge_pkg::size_e         pick_size;
    logic [`BR_PADDR_W-1:0]        pick_addr;
    logic [`BR_WORD_W-1:0]         pick_data;

    // imiss first, then load, then store
    always_comb begin
        pick_val  = 1'b0;
        pick_type = l15_bridge_pkg::LOAD_RQ;
        pick_size = l15_bridge_pkg::SZ_16B;
        pick_addr = '0;
        pick_data = '0;
        if (slot.imiss_pend) begin
            pick_val  = 1'b1;
            pick_type = l15_bridge_pkg::IMISS_RQ;
            pick_size = l15_bridge_pkg::SZ_4B;
            pick_addr = slot.imiss_addr;
        end else if (slot.load_pend) begin
            pick_val  = 1'b1;
            pick_type = l15_bridge_pkg::LOAD_RQ;
            pick_size = l15_bridge_pkg::SZ_16B;
            pick_addr = slot.load_addr;
        end else if (slot.store_pend) begin
            pick_val  = 1'b1;
            pick_type = l15_bridge_pkg::STORE_RQ;
            pick_size = slot.store_size;
            pick_addr = slot.store_addr;
            pick_data = slot.store_data;
        end
    end

    // one request in flight, dropped on ack, so val is low for a cycle after each ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (outstanding) begin
            if (l15_ack_i) begin
                outstanding <= 1'b0;
            end
        end else begin
            outstanding <= pick_val;
        end
    end

    // request fields only load when idle, held steady until the ack
    always_ff @(posedge clk) begin
        if (!outstanding && pick_val) begin
            l15_rqtype_o <= pick_type;
            l15_size_o   <= pick_size;
            l15_addr_o   <= pick_addr;
            l15_data_o   <= pick_data;
        end
    end

    assign l15_val_o = outstanding;
    assign l15_nc_o  = l15_addr_o[`BR_PADDR_W-1];

    // release the slot that was acked
    assign ack_hit         = outstanding & l15_ack_i;
    assign slot.imiss_take = ack_hit & (l15_rqtype_o == l15_bridge_pkg::IMISS_RQ);
    assign slot.load_take  = ack_hit & (l15_rqtype_o == l15_bridge_pkg::LOAD_RQ);
    assign slot.store_take = ack_hit & (l15_rqtype_o == l15_bridge_pkg::STORE_RQ);

endmodule

`default_nettype wire

/* source/req_capture.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_bridge_params.svh"

module req_capture (
    input  logic                    clk,
    input  logic                    rst_n,

    // icache miss
    input  logic                    ic_req_val_i,
    input  logic [`BR_IC_BLK_W-1:0] ic_req_addr_i,

    // dcache load miss
    input  logic                    dc_ld_val_i,
    input  logic [`BR_DC_BLK_W-1:0] dc_ld_addr_i,

    // dcache store
    input  logic                    dc_st_val_i,
    input  logic [`BR_PADDR_W-1:0]  dc_st_addr_i,
    input  logic [`BR_WORD_W-1:0]   dc_st_data_i,
    input  logic [2:0]              dc_st_size_i,

    req_slot_if.capture             slot
);

    logic [`BR_PADDR_W-1:0] imiss_byte_addr;
    logic [`BR_PADDR_W-1:0] load_byte_addr;
    logic [`BR_WORD_W-1:0]  store_data_sw;

    // block addresses back to byte addresses
    assign imiss_byte_addr = `BR_PADDR_W'({ic_req_addr_i, {`BR_IC_OFS_W{1'b0}}});
    assign load_byte_addr  = `BR_PADDR_W'({dc_ld_addr_i, {`BR_DC_OFS_W{1'b0}}});

    // L1.5 wants the other byte order
    assign store_data_sw = l15_bridge_pkg::swap_bytes64(dc_st_data_i);

    // pend bits, a new request wins over a take in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot.imiss_pend <= 1'b0;
            slot.load_pend  <= 1'b0;
            slot.store_pend <= 1'b0;
        end else begin
            if (ic_req_val_i) begin
                slot.imiss_pend <= 1'b1;
            end else if (slot.imiss_take) begin
                slot.imiss_pend <= 1'b0;
            end

            if (dc_ld_val_i) begin
                slot.load_pend <= 1'b1;
            end else if (slot.load_take) begin
                slot.load_pend <= 1'b0;
            end

            if (dc_st_val_i) begin
                slot.store_pend <= 1'b1;
            end else if (slot.store_take) begin
                slot.store_pend <= 1'b0;
            end
        end
    end

    // slot contents, only meaningful while pend is set
    always_ff @(posedge clk) begin
        if (ic_req_val_i) begin
            slot.imiss_addr <= imiss_byte_addr;
        end
        if (dc_ld_val_i) begin
            slot.load_addr <= load_byte_addr;
        end
        if (dc_st_val_i) begin
            slot.store_addr <= dc_st_addr_i;
            slot.store_data <= store_data_sw;
            slot.store_size <= l15_bridge_pkg::size_e'(dc_st_size_i);
        end
    end

endmodule

`default_nettype wire

/* source/req_slot_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_bridge_params.svh"

interface req_slot_if;

    // pending slots, owned by capture
    logic                     imiss_pend;
    logic [`BR_PADDR_W-1:0]   imiss_addr;
    logic                     load_pend;
    logic [`BR_PADDR_W-1:0]   load_addr;
    logic                     store_pend;
    logic [`BR_PADDR_W-1:0]   store_addr;
    logic [`BR_WORD_W-1:0]    store_data;
    l15_bridge_pkg::size_e    store_size;

    // one-cycle pulses from issue when the L1.5 acks a slot
    logic                     imiss_take;
    logic                     load_take;
    logic                     store_take;

    modport capture (
        output imiss_pend, imiss_addr, load_pend, load_addr,
        output store_pend, store_addr, store_data, store_size,
        input  imiss_take, load_take, store_take
    );

    modport issue (
        input  imiss_pend, imiss_addr, load_pend, load_addr,
        input  store_pend, store_addr, store_data, store_size,
        output imiss_take, load_take, store_take
    );

endinterface

`default_nettype wire

/* source/l15_bridge_pkg.sv */
`default_nettype none

`include "l15_bridge_params.svh"

package l15_bridge_pkg;

    // request codes on l15_rqtype_o
    typedef enum logic [4:0] {
        LOAD_RQ  = 5'b00000,
        STORE_RQ = 5'b00001,
        IMISS_RQ = 5'b10000
    } rqtype_e;

    typedef enum logic [2:0] {
        SZ_4B  = 3'b010,
        SZ_16B = 3'b111
    } size_e;

    // return codes from the L1.5
    typedef enum logic [3:0] {
        LOAD_RET  = 4'b0000,
        IFILL_RET = 4'b0001,
        ST_ACK    = 4'b0100,
        INT_RET   = 4'b0111
    } rettype_e;

    typedef struct packed {
        logic [`BR_TAG_W-1:0]    tag;
        logic [`BR_IC_IDX_W-1:0] idx;
        logic [`BR_IC_OFS_W-1:0] ofs;
    } ic_addr_t;

    typedef struct packed {
        logic [`BR_TAG_W-1:0]    tag;
        logic [`BR_DC_IDX_W-1:0] idx;
        logic [`BR_DC_OFS_W-1:0] ofs;
    } dc_addr_t;

    // same return address, seen by either cache
    typedef union packed {
        ic_addr_t ic;
        dc_addr_t dc;
    } fill_addr_u;

    // byte 0 goes to byte 7 and so on
    function automatic logic [`BR_WORD_W-1:0] swap_bytes64(input logic [`BR_WORD_W-1:0] w);
        logic [`BR_WORD_W-1:0] res;
        for (int b = 0; b < 8; b++) begin
            res[b*8 +: 8] = w[(7-b)*8 +: 8];
        end
        return res;
    endfunction

    // word order kept, only bytes inside each word flip
    function automatic logic [`BR_IC_LINE_W-1:0] swap_line(input logic [`BR_IC_LINE_W-1:0] line);
        logic [`BR_IC_LINE_W-1:0] res;
        for (int i = 0; i < `BR_IC_LINE_W / `BR_WORD_W; i++) begin
            res[i*`BR_WORD_W +: `BR_WORD_W] = swap_bytes64(line[i*`BR_WORD_W +: `BR_WORD_W]);
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* source/l15_bridge_params.svh */
`ifndef L15_BRIDGE_PARAMS_SVH
`define L15_BRIDGE_PARAMS_SVH

// physical address seen by the L1.5
`define BR_PADDR_W    40

// block addresses from the core caches
// icache lines are 32 bytes, dcache lines are 16 bytes
`define BR_IC_BLK_W   35
`define BR_DC_BLK_W   36

// store word and return word
`define BR_WORD_W     64

// full cache lines handed back to the core
`define BR_IC_LINE_W  256
`define BR_DC_LINE_W  128

// return address split, tag on top and offset at the bottom
`define BR_TAG_W      29
`define BR_IC_IDX_W   6
`define BR_IC_OFS_W   5
`define BR_DC_IDX_W   7
`define BR_DC_OFS_W   4

`endif
